// ==== all.f ====
+incdir+.
isolde_regfile_pkg.sv
isolde_decoder_pkg.sv
isolde_fetch_window.sv
isolde_decoder.sv
isolde_qreg_file.sv
isolde_issue_stage.sv
isolde_frontend_top.sv
tb_isolde_frontend.sv

// ==== isolde_decoder.sv ====
/*
  variable length instruction decoder
  boot delay, length wait, quad word load, gemm unpack, illegal drop
*/
`timescale 1ns/1ps
`default_nettype none
`include "isolde_defines.svh"

module isolde_decoder (
  input  wire                               clk_i,
  input  wire                               rst_ni,
  input  wire isolde_decoder_pkg::instr_batch_t batch_i,
  input  wire  [2:0]                        words_avail_i,
  input  wire                               stall_i,        // issue stage full
  output logic                              consume_o,
  output logic [2:0]                        consume_cnt_o,
  output isolde_regfile_pkg::qreg_wr_t      qreg_wr_o,
  output logic                              op_valid_o,
  output isolde_decoder_pkg::gemm_op_t      op_o,
  output logic                              illegal_o,
  output logic                              busy_o
);

  localparam int BootCycles = `ISOLDE_BOOT_CYCLES;
  localparam int BootW      = $clog2(BootCycles + 1);

  typedef enum logic [2:0] {
    BOOT,
    IDLE,
    FETCH_COMPUTE,   // decode word 0
    FETCH_REST,      // wait for the remaining words
    STALL            // gemm ready but issue stage blocked
  } state_e;

  state_e state_q, state_d;
  logic [BootW-1:0] boot_cnt_q;

  isolde_decoder_pkg::isolde_opcode_e opcode_d, opcode_q;
  logic [2:0] len_q;  // words in the current instruction

  logic        emit;    // instruction complete and accepted
  logic        reject;  // word 0 not a known instruction
  logic [31:0] w0, w1;

  logic                           we_q;
  isolde_regfile_pkg::qreg_addr_t waddr_q;
  isolde_regfile_pkg::qreg_data_t wdata_q;

  assign w0 = batch_i[0];
  assign w1 = batch_i[1];

  // opcode from word 0
  always_comb begin
    opcode_d = isolde_decoder_pkg::isolde_opcode_invalid;
    if (w0[6:0] == `ISOLDE_OPC_CUSTOM) begin
      case (w0[14:12])
        `ISOLDE_F3_VLE32_4: opcode_d = isolde_decoder_pkg::isolde_opcode_vle32_4;
        `ISOLDE_F3_GEMM:    opcode_d = isolde_decoder_pkg::isolde_opcode_gemm;
        default:            opcode_d = isolde_decoder_pkg::isolde_opcode_invalid;
      endcase
    end
  end

  always_comb begin
    state_d = state_q;
    emit    = 1'b0;
    reject  = 1'b0;
    case (state_q)
      BOOT: begin
        if (boot_cnt_q == BootW'(BootCycles - 1)) state_d = IDLE;
      end
      IDLE: begin
        // window has not shifted yet while consume is out
        if ((words_avail_i != 3'd0) && !consume_o) state_d = FETCH_COMPUTE;
      end
      FETCH_COMPUTE: begin
        if (opcode_d == isolde_decoder_pkg::isolde_opcode_invalid) begin
          reject  = 1'b1;
          state_d = IDLE;
        end else begin
          state_d = FETCH_REST;
        end
      end
      FETCH_REST: begin
        if (words_avail_i >= len_q) begin
          if ((opcode_q == isolde_decoder_pkg::isolde_opcode_gemm) && stall_i) begin
            state_d = STALL;
          end else begin
            emit    = 1'b1;
            state_d = IDLE;
          end
        end
      end
      STALL: begin
        if (!stall_i) begin
          emit    = 1'b1;  // words still sit in the window
          state_d = IDLE;
        end
      end
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q       <= BOOT;
      boot_cnt_q    <= '0;
      opcode_q      <= isolde_decoder_pkg::isolde_opcode_invalid;
      len_q         <= '0;
      consume_o     <= 1'b0;
      consume_cnt_o <= '0;
      illegal_o     <= 1'b0;
      we_q          <= 1'b0;
      op_valid_o    <= 1'b0;
    end else begin
      state_q <= state_d;
      if (state_q == BOOT) boot_cnt_q <= boot_cnt_q + 1'b1;
      if (state_q == FETCH_COMPUTE) begin
        opcode_q <= opcode_d;
        len_q    <= isolde_decoder_pkg::instr_len(opcode_d);
      end
      consume_o     <= emit | reject;
      consume_cnt_o <= reject ? 3'd1 : (emit ? len_q : 3'd0);
      illegal_o     <= reject;
      we_q          <= emit && (opcode_q == isolde_decoder_pkg::isolde_opcode_vle32_4);
      op_valid_o    <= emit && (opcode_q == isolde_decoder_pkg::isolde_opcode_gemm);
    end
  end

  // shared payload for the write and the op
  always_ff @(posedge clk_i) begin
    if (emit) begin
      waddr_q     <= w0[11:7];
      wdata_q     <= {w1, batch_i[2], batch_i[3], batch_i[4]};  // lane 3 is word 1
      op_o.func3  <= w0[14:12];
      op_o.funct2 <= w0[26:25];
      op_o.rd1    <= w0[31:27];
      op_o.rd2    <= w0[11:7];
      op_o.rs4    <= w1[4:0];
      op_o.rs5    <= w1[9:5];
      op_o.rs1    <= w1[14:10];
      op_o.rs2    <= w1[19:15];
      op_o.rs3    <= w1[24:20];
    end
  end

  assign qreg_wr_o.we    = we_q;
  assign qreg_wr_o.waddr = waddr_q;
  assign qreg_wr_o.wdata = wdata_q;

  assign busy_o = (state_q != IDLE);  // boot or instruction in flight

  a_one_target: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(qreg_wr_o.we && op_valid_o));

endmodule

`default_nettype wire

// ==== isolde_decoder_pkg.sv ====
/*
  decoder types
  opcode enum, instruction batch, decoded and issued gemm ops, length function
*/
`default_nettype none
`include "isolde_defines.svh"

package isolde_decoder_pkg;

  typedef enum logic [1:0] {
    isolde_opcode_invalid = 2'd0,
    isolde_opcode_vle32_4 = 2'd1,
    isolde_opcode_gemm    = 2'd2
  } isolde_opcode_e;

  // word 0 is the oldest word in the window
  typedef logic [`ISOLDE_BATCH_WORDS-1:0][31:0] instr_batch_t;

  // unpacked gemm fields
  typedef struct packed {
    logic [2:0]                     func3;
    logic [1:0]                     funct2;
    logic [4:0]                     rd1;    // gpr
    logic [4:0]                     rd2;
    logic [4:0]                     rs1;    // gpr
    logic [4:0]                     rs2;    // gpr
    logic [4:0]                     rs3;    // gpr
    isolde_regfile_pkg::qreg_addr_t rs4;    // quad operand a
    isolde_regfile_pkg::qreg_addr_t rs5;    // quad operand b
  } gemm_op_t;

  // gemm plus its two quad operands
  typedef struct packed {
    gemm_op_t                       op;
    isolde_regfile_pkg::qreg_data_t a;
    isolde_regfile_pkg::qreg_data_t b;
  } issue_op_t;

  // instruction length in words
  function automatic logic [2:0] instr_len(isolde_opcode_e opc);
    case (opc)
      isolde_opcode_vle32_4: return 3'd5;
      isolde_opcode_gemm:    return 3'd2;
      default:               return 3'd1;  // invalid drops a single word
    endcase
  endfunction

endpackage

`default_nettype wire

// ==== isolde_defines.svh ====
/*
  shared constants for the front end
  batch depth, boot delay, custom major opcode and func3 codes
*/
`ifndef ISOLDE_DEFINES_SVH
`define ISOLDE_DEFINES_SVH

// words held by the fetch window
`define ISOLDE_BATCH_WORDS 5

// cycles the decoder stays in boot after reset
`define ISOLDE_BOOT_CYCLES 6

// custom-0 major opcode
`define ISOLDE_OPC_CUSTOM 7'b0001011

`define ISOLDE_F3_VLE32_4 3'd0  // quad word load
`define ISOLDE_F3_GEMM    3'd1  // two word gemm

`endif

// ==== isolde_fetch_window.sv ====
/*
  fetch window
  five word shift buffer, filled by a word strobe, drained by decoder consume
*/
`timescale 1ns/1ps
`default_nettype none
`include "isolde_defines.svh"

module isolde_fetch_window (
  input  wire                               clk_i,
  input  wire                               rst_ni,
  input  wire                               word_valid_i,
  input  wire  [31:0]                       word_i,
  input  wire                               consume_i,     // one cycle pulse
  input  wire  [2:0]                        consume_cnt_i,
  output isolde_decoder_pkg::instr_batch_t  batch_o,
  output logic [2:0]                        words_avail_o
);

  localparam int Words = `ISOLDE_BATCH_WORDS;

  isolde_decoder_pkg::instr_batch_t buf_q, buf_d;
  logic [2:0] cnt_q, cnt_d;
  logic [2:0] n_drop;  // words retired this cycle

  // retire first, then append behind what is left
  always_comb begin
    n_drop = consume_i ? consume_cnt_i : 3'd0;
    buf_d  = buf_q >> {n_drop, 5'b0_0000};  // shift by whole words
    cnt_d  = cnt_q - n_drop;
    if (word_valid_i && (cnt_d < Words)) begin
      buf_d[cnt_d] = word_i;   // first free slot
      cnt_d        = cnt_d + 3'd1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q <= '0;
    end else begin
      cnt_q <= cnt_d;
    end
  end

  always_ff @(posedge clk_i) begin
    buf_q <= buf_d;  // slots above cnt_q are don't care
  end

  assign batch_o       = buf_q;
  assign words_avail_o = cnt_q;

  // source holds off while the window is full
  a_no_overflow: assert property (@(posedge clk_i) disable iff (!rst_ni)
    word_valid_i |-> (cnt_q < Words));

  // decoder only retires words it has seen
  a_no_underflow: assert property (@(posedge clk_i) disable iff (!rst_ni)
    consume_i |-> (consume_cnt_i <= cnt_q));

endmodule

`default_nettype wire

// ==== isolde_frontend_top.sv ====
/*
  front end top
  fetch window, decoder, quad register file and issue stage
*/
`timescale 1ns/1ps
`default_nettype none

module isolde_frontend_top (
  input  wire                           clk_i,
  input  wire                           rst_ni,
  input  wire                           word_valid_i,
  input  wire [31:0]                    word_i,
  input  wire                           exec_stall_i,
  output logic [2:0]                    words_avail_o,
  output logic                          busy_o,
  output logic                          illegal_o,
  output logic                          issue_valid_o,
  output isolde_decoder_pkg::issue_op_t issue_o
);

  isolde_decoder_pkg::instr_batch_t batch;
  logic                             consume;
  logic [2:0]                       consume_cnt;
  isolde_regfile_pkg::qreg_wr_t     qreg_wr;
  logic                             op_valid;
  isolde_decoder_pkg::gemm_op_t     op;
  logic                             stall;
  isolde_regfile_pkg::qreg_addr_t   raddr_a, raddr_b;
  isolde_regfile_pkg::qreg_data_t   rdata_a, rdata_b;

  isolde_fetch_window u_window (
    .clk_i, .rst_ni, .word_valid_i, .word_i,
    .consume_i     (consume),
    .consume_cnt_i (consume_cnt),
    .batch_o       (batch),
    .words_avail_o (words_avail_o)
  );

  isolde_decoder u_decoder (
    .clk_i, .rst_ni,
    .batch_i       (batch),
    .words_avail_i (words_avail_o),  // same count the source sees
    .stall_i       (stall),
    .consume_o     (consume),
    .consume_cnt_o (consume_cnt),
    .qreg_wr_o     (qreg_wr),
    .op_valid_o    (op_valid),
    .op_o          (op),
    .illegal_o, .busy_o
  );

  isolde_qreg_file u_qregs (
    .clk_i, .rst_ni,
    .wr_i      (qreg_wr),
    .raddr_a_i (raddr_a),
    .raddr_b_i (raddr_b),
    .rdata_a_o (rdata_a),
    .rdata_b_o (rdata_b)
  );

  isolde_issue_stage u_issue (
    .clk_i, .rst_ni,
    .op_valid_i (op_valid),
    .op_i       (op),
    .exec_stall_i,
    .stall_o    (stall),
    .raddr_a_o  (raddr_a),
    .raddr_b_o  (raddr_b),
    .rdata_a_i  (rdata_a),
    .rdata_b_i  (rdata_b),
    .issue_valid_o, .issue_o
  );

endmodule

`default_nettype wire

// ==== isolde_issue_stage.sv ====
/*
  gemm issue stage
  captures op with both quad operands, holds it while execution stalls
*/
`timescale 1ns/1ps
`default_nettype none

module isolde_issue_stage (
  input  wire                                 clk_i,
  input  wire                                 rst_ni,
  input  wire                                 op_valid_i,   // one cycle pulse
  input  wire isolde_decoder_pkg::gemm_op_t   op_i,
  input  wire                                 exec_stall_i,
  output logic                                stall_o,
  output isolde_regfile_pkg::qreg_addr_t      raddr_a_o,
  output isolde_regfile_pkg::qreg_addr_t      raddr_b_o,
  input  wire isolde_regfile_pkg::qreg_data_t rdata_a_i,
  input  wire isolde_regfile_pkg::qreg_data_t rdata_b_i,
  output logic                                issue_valid_o,
  output isolde_decoder_pkg::issue_op_t       issue_o
);

  // operand lookup straight from the incoming op
  assign raddr_a_o = op_i.rs4;
  assign raddr_b_o = op_i.rs5;

  // held op blocks the next one
  assign stall_o = issue_valid_o && exec_stall_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      issue_valid_o <= 1'b0;
    end else if (op_valid_i) begin
      issue_valid_o <= 1'b1;
    end else if (!exec_stall_i) begin
      issue_valid_o <= 1'b0;  // taken by execution
    end
  end

  always_ff @(posedge clk_i) begin
    if (op_valid_i) begin
      issue_o.op <= op_i;
      issue_o.a  <= rdata_a_i;  // quad data read in the same cycle
      issue_o.b  <= rdata_b_i;
    end
  end

  // decoder must wait in STALL so no op is dropped
  a_no_drop: assert property (@(posedge clk_i) disable iff (!rst_ni)
    op_valid_i |-> !stall_o);

endmodule

`default_nettype wire

// ==== isolde_qreg_file.sv ====
/*
  quad register file
  32 x 128 bit, one write port, two combinational read ports
*/
`timescale 1ns/1ps
`default_nettype none

module isolde_qreg_file (
  input  wire                                 clk_i,
  input  wire                                 rst_ni,
  input  wire isolde_regfile_pkg::qreg_wr_t   wr_i,
  input  wire isolde_regfile_pkg::qreg_addr_t raddr_a_i,
  input  wire isolde_regfile_pkg::qreg_addr_t raddr_b_i,
  output isolde_regfile_pkg::qreg_data_t      rdata_a_o,
  output isolde_regfile_pkg::qreg_data_t      rdata_b_o
);

  localparam int NumRegs = 2 ** $bits(isolde_regfile_pkg::qreg_addr_t);

  isolde_regfile_pkg::qreg_data_t regs_q [NumRegs];

  // registers come up as zero
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < NumRegs; i++) begin
        regs_q[i] <= '0;
      end
    end else if (wr_i.we) begin
      regs_q[wr_i.waddr] <= wr_i.wdata;  // readable next cycle
    end
  end

  // no write bypass
  assign rdata_a_o = regs_q[raddr_a_i];
  assign rdata_b_o = regs_q[raddr_b_i];

endmodule

`default_nettype wire

// ==== isolde_regfile_pkg.sv ====
/*
  quad register file types
  register index, four lane data word, write port
*/
`default_nettype none

package isolde_regfile_pkg;

  // 32 quad registers
  typedef logic [4:0] qreg_addr_t;

  // lane 3 in the top bits, lane 0 at the bottom
  typedef logic [3:0][31:0] qreg_data_t;

  // single write port
  typedef struct packed {
    logic       we;     // one cycle write strobe
    qreg_addr_t waddr;
    qreg_data_t wdata;
  } qreg_wr_t;

endpackage

`default_nettype wire

// ==== tb_isolde_frontend.sv ====
/*
  directed testbench for the front end
  word driver, issue monitor, compare tasks and five tests
*/
`timescale 1ns/1ps
`default_nettype none
`include "isolde_defines.svh"

module tb_isolde_frontend;

  logic        clk_i, rst_ni, word_valid_i, exec_stall_i;
  logic [31:0] word_i;
  logic [2:0]  words_avail_o;
  logic        busy_o, illegal_o, issue_valid_o;
  isolde_decoder_pkg::issue_op_t issue_o;

  integer seed = 32'h75e570ea;
  int     errors = 0;
  int     checks = 0;
  int     illegal_cnt = 0;  // illegal_o pulses seen
  string  test_name = "reset";
  isolde_decoder_pkg::issue_op_t  issued_q [$];      // ops taken by execution, in order
  isolde_regfile_pkg::qreg_data_t qreg_model [32];  // expected quad register contents

  isolde_frontend_top dut0 (
    .clk_i, .rst_ni, .word_valid_i, .word_i, .exec_stall_i,
    .words_avail_o, .busy_o, .illegal_o, .issue_valid_o, .issue_o
  );

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  // an op is taken when valid and execution is not stalled
  initial begin
    forever begin
      @(posedge clk_i);
      #2;  // registered outputs settled
      if (rst_ni && issue_valid_o && !exec_stall_i) issued_q.push_back(issue_o);
      if (rst_ni && illegal_o) illegal_cnt++;
    end
  end

  task automatic check_bit(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Fail %s in %s: got %h expected %h", name, test_name, got, exp);
    end
  endtask

  task automatic check_count(input string name, input logic [2:0] got, input logic [2:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Fail %s in %s: got %h expected %h", name, test_name, got, exp);
    end
  endtask

  task automatic check_qreg(input string name, input isolde_regfile_pkg::qreg_data_t got,
                            input isolde_regfile_pkg::qreg_data_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Fail %s in %s: got %h expected %h", name, test_name, got, exp);
    end
  endtask

  task automatic check_issue(input string name, input isolde_decoder_pkg::issue_op_t got,
                             input isolde_decoder_pkg::issue_op_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Fail %s in %s: got %h expected %h", name, test_name, got, exp);
    end
  endtask

  task automatic next_cycle();
    @(posedge clk_i);
    #1;  // inputs change 1 ns after the edge
  endtask

  // one word strobe held off while the window is full
  task automatic send_word(input logic [31:0] w);
    int waited = 0;
    while (words_avail_o == `ISOLDE_BATCH_WORDS && waited < 100) begin
      next_cycle();
      waited++;
    end
    if (words_avail_o == `ISOLDE_BATCH_WORDS) begin
      errors++;
      $display("%s: fetch window stayed full, word %h was not sent", test_name, w);
    end else begin
      word_valid_i = 1'b1;
      word_i       = w;
      next_cycle();
      word_valid_i = 1'b0;
    end
  endtask

  function automatic isolde_regfile_pkg::qreg_data_t rand_lanes();
    isolde_regfile_pkg::qreg_data_t d;
    for (int i = 0; i < 4; i++) d[i] = $random(seed);
    return d;
  endfunction

  function automatic isolde_decoder_pkg::gemm_op_t rand_gemm(input logic [4:0] rs4, rs5);
    isolde_decoder_pkg::gemm_op_t op;
    logic [31:0] r;
    r         = $random(seed);
    op.func3  = `ISOLDE_F3_GEMM;
    op.funct2 = r[1:0];
    op.rd1    = r[6:2];
    op.rd2    = r[11:7];
    op.rs1    = r[16:12];
    op.rs2    = r[21:17];
    op.rs3    = r[26:22];
    op.rs4    = rs4;
    op.rs5    = rs5;
    return op;
  endfunction

  // operands come from the register model
  function automatic isolde_decoder_pkg::issue_op_t expected_issue(
      input isolde_decoder_pkg::gemm_op_t op);
    isolde_decoder_pkg::issue_op_t e;
    e.op = op;
    e.a  = qreg_model[op.rs4];
    e.b  = qreg_model[op.rs5];
    return e;
  endfunction

  task automatic load_qreg(input logic [4:0] addr, input isolde_regfile_pkg::qreg_data_t d);
    send_word({17'h0, `ISOLDE_F3_VLE32_4, addr, `ISOLDE_OPC_CUSTOM});
    for (int i = 3; i >= 0; i--) send_word(d[i]);  // word 1 carries lane 3
    qreg_model[addr] = d;
  endtask

  // gap counts idle cycles between the two words
  // pad bits are don't care
  task automatic send_gemm(input isolde_decoder_pkg::gemm_op_t op, input int gap);
    logic [31:0] pad;
    pad = $random(seed);
    send_word({op.rd1, op.funct2, pad[9:0], `ISOLDE_F3_GEMM, op.rd2, `ISOLDE_OPC_CUSTOM});
    repeat (gap) next_cycle();
    send_word({pad[31:25], op.rs3, op.rs2, op.rs1, op.rs5, op.rs4});
  endtask

  task automatic wait_issue(output isolde_decoder_pkg::issue_op_t got);
    int waited = 0;
    got = '0;
    while (issued_q.size() == 0 && waited < 200) begin
      next_cycle();
      waited++;
    end
    if (issued_q.size() == 0) begin
      errors++;
      $display("%s: no op issued within 200 cycles", test_name);
    end else begin
      got = issued_q.pop_front();
    end
  endtask

  // nothing more may issue and the window is drained
  task automatic expect_no_issue();
    repeat (10) next_cycle();
    checks++;
    if (issued_q.size() != 0) begin
      errors++;
      $display("%s: %0d unexpected extra issue(s)", test_name, issued_q.size());
      issued_q.delete();
    end
    check_count("words_avail_o", words_avail_o, 3'd0);
  endtask

  task automatic boot_busy();
    int waited = 0;
    test_name = "boot";
    check_bit("busy_o", busy_o, 1'b1);
    check_count("words_avail_o", words_avail_o, 3'd0);
    while (busy_o && waited < `ISOLDE_BOOT_CYCLES + 2) begin
      next_cycle();
      waited++;
      check_bit("issue_valid_o", issue_valid_o, 1'b0);
      check_bit("illegal_o", illegal_o, 1'b0);
    end
    if (busy_o) begin
      errors++;
      $display("boot: busy_o still high %0d cycles after reset", waited);
    end
  endtask

  task automatic load_then_gemm();
    isolde_regfile_pkg::qreg_data_t la, lb;
    isolde_decoder_pkg::gemm_op_t   op;
    isolde_decoder_pkg::issue_op_t  got;
    test_name = "load_gemm";
    la = rand_lanes();
    lb = rand_lanes();
    load_qreg(5'd3, la);
    load_qreg(5'd7, lb);
    op = rand_gemm(5'd3, 5'd7);
    send_gemm(op, 0);
    wait_issue(got);
    check_qreg("issue_o.a", got.a, la);
    check_qreg("issue_o.b", got.b, lb);
    check_issue("issue_o", got, expected_issue(op));
    expect_no_issue();
  endtask

  task automatic slow_arrival();
    isolde_decoder_pkg::gemm_op_t  op;
    isolde_decoder_pkg::issue_op_t got;
    logic [31:0] r;
    test_name = "slow_gemm";
    r  = $random(seed);
    op = rand_gemm(r[4:0], r[9:5]);
    send_gemm(op, 6);
    wait_issue(got);
    check_issue("issue_o", got, expected_issue(op));
    expect_no_issue();
  endtask

  task automatic illegal_drop();
    isolde_decoder_pkg::gemm_op_t  op;
    isolde_decoder_pkg::issue_op_t got;
    logic [31:0] r;
    int base;
    test_name = "illegal";
    base = illegal_cnt;
    r    = $random(seed);
    send_word({r[31:7], 7'b0110011});  // not the custom opcode
    op = rand_gemm(5'd7, 5'd3);
    send_gemm(op, 0);
    wait_issue(got);
    check_issue("issue_o", got, expected_issue(op));
    expect_no_issue();
    checks++;
    if (illegal_cnt != base + 1) begin
      errors++;
      $display("illegal: illegal_o pulsed %0d times instead of once", illegal_cnt - base);
    end
  endtask

  task automatic stall_two_gemms();
    isolde_decoder_pkg::gemm_op_t  op1, op2;
    isolde_decoder_pkg::issue_op_t got;
    int waited = 0;
    test_name = "backpressure";
    op1 = rand_gemm(5'd3, 5'd0);
    op2 = rand_gemm(5'd7, 5'd3);
    exec_stall_i = 1'b1;
    send_gemm(op1, 0);
    send_gemm(op2, 0);
    while (!issue_valid_o && waited < 100) begin
      next_cycle();
      waited++;
    end
    repeat (20) next_cycle();  // second gemm waits behind the held one
    check_bit("issue_valid_o", issue_valid_o, 1'b1);
    check_issue("issue_o", issue_o, expected_issue(op1));
    if (issued_q.size() != 0) begin
      errors++;
      $display("backpressure: an op was taken while exec_stall_i was high");
    end
    exec_stall_i = 1'b0;
    wait_issue(got);
    check_issue("issue_o", got, expected_issue(op1));
    wait_issue(got);
    check_issue("issue_o", got, expected_issue(op2));
    expect_no_issue();
  endtask

  initial begin
    rst_ni       = 1'b0;
    word_valid_i = 1'b0;
    word_i       = '0;
    exec_stall_i = 1'b0;
    for (int i = 0; i < 32; i++) qreg_model[i] = '0;  // registers reset to zero
    repeat (4) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;
    boot_busy();
    load_then_gemm();
    slow_arrival();
    illegal_drop();
    stall_two_gemms();
    $display("errors: %0d, checks: %0d", errors, checks);
    if (errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

`default_nettype wire
